// File: mbus_pkg.sv
/*
 * Main bus shared definitions
 * Address map constants, bus widths and the enums used by the arbiter blocks
 */
`default_nettype none

package mbus_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	// 68000 word address, bits 23 down to 1
	localparam int ADDR_W    = 23;
	localparam int DATA_W    = 16;
	localparam int RAM_AW    = 15;
	localparam int RAM_WORDS = 1 << RAM_AW;
	localparam int BANK_W    = 5;
	localparam int NUM_BANKS = 8;

	// Open-bus word after reset (68000 NOP)
	localparam logic [DATA_W-1:0] NOP_WORD = 16'h4E71;

	// ------------------------------
	// Address map
	// ------------------------------
	// Everything below this top nibble is cartridge space
	localparam logic [3:0]  ROM_LIMIT_HI = 4'hA;
	// Z80 bus request and reset registers
	localparam logic [11:0] CTRL_PAGE    = 12'hA11;
	// Mapper bank registers
	localparam logic [15:0] BANK_PAGE    = 16'hA130;

	// ------------------------------
	// Enums
	// ------------------------------
	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		ROM_READ,
		ROM_WAIT,
		RAM_READ,
		FINISH
	} mstate_t;

	typedef enum logic [1:0] {
		NONE,
		CPU,
		DMA
	} msrc_t;

	typedef enum logic [2:0] {
		ROM,
		ROM_EMPTY,
		CTRL,
		BANK,
		RAM,
		UNMAPPED
	} region_t;

	typedef enum logic {
		LINEAR,
		BANKED
	} bank_mode_t;

endpackage

`default_nettype wire

// File: mbus_decode.sv
/*
 * Main bus address decoder
 * Classifies the latched bus address into one of the mapped regions
 */
`default_nettype none
`timescale 1ns/1ps

module mbus_decode (
	input  wire logic [mbus_pkg::ADDR_W:1] bus_addr,
	input  wire logic [mbus_pkg::ADDR_W:1] rom_size,
	output mbus_pkg::region_t              region
);

	import mbus_pkg::*;

	logic in_rom_space;
	logic ctrl_hit;
	logic bank_hit;
	logic ram_hit;

	// Cartridge space, 000000 to 9FFFFF
	assign in_rom_space = bus_addr[23:20] < ROM_LIMIT_HI;

	// Only A11100 and A11200 respond, low byte of the page must be zero
	assign ctrl_hit = (bus_addr[23:12] == CTRL_PAGE)
		&& ((bus_addr[11:8] == 4'h1) || (bus_addr[11:8] == 4'h2))
		&& (bus_addr[7:1] == 7'd0);

	// A130xx page
	assign bank_hit = bus_addr[23:8] == BANK_PAGE;

	// E00000 to FFFFFF, the 64 KB repeats across the range
	assign ram_hit = &bus_addr[23:21];

	always_comb begin
		if (in_rom_space) begin
			// Past the end of the loaded image reads as empty
			if (bus_addr < rom_size)
				region = ROM;
			else
				region = ROM_EMPTY;
		end else if (ctrl_hit) begin
			region = CTRL;
		end else if (bank_hit) begin
			region = BANK;
		end else if (ram_hit) begin
			region = RAM;
		end else begin
			region = UNMAPPED;
		end
	end

endmodule

`default_nettype wire

// File: system_regs.sv
/*
 * System control and bank registers
 * Z80 bus request and reset, ROM bank mapper and ROM address translation
 */
`default_nettype none
`timescale 1ns/1ps

module system_regs (
	input  wire logic                      MCLK,
	input  wire logic                      reset,
	input  wire logic                      ctrl_wr,
	input  wire logic                      bank_wr,
	input  wire logic [mbus_pkg::ADDR_W:1] bus_addr,
	input  wire logic [mbus_pkg::DATA_W-1:0] bus_wdata,
	input  wire logic                      z80_busak_n,
	output logic                           ctrl_rdbit,
	output logic [mbus_pkg::ADDR_W:1]      rom_addr,
	output logic                           z80_busreq_n,
	output logic                           z80_reset_n
);

	import mbus_pkg::*;

	logic [BANK_W-1:0] bank_reg [NUM_BANKS];
	bank_mode_t        bank_mode;
	logic              sel_reset_reg;

	// A11200 when page nibble is 2, otherwise A11100
	assign sel_reset_reg = bus_addr[11:8] == 4'h2;

	// ------------------------------
	// Z80 control
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else if (ctrl_wr) begin
			if (sel_reset_reg)
				z80_reset_n <= bus_wdata[8];
			else
				z80_busreq_n <= ~bus_wdata[8];
		end
	end

	// Read-back shows the grant, not the request
	assign ctrl_rdbit = sel_reset_reg ? z80_reset_n : z80_busak_n;

	// ------------------------------
	// Bank mapper
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_mode <= LINEAR;
			for (int i = 0; i < NUM_BANKS; i++)
				bank_reg[i] <= BANK_W'(i);
		end else if (bank_wr && (bus_addr[3:1] != 3'd0)) begin
			// Slot 0 stays fixed so the vector table is always reachable
			bank_reg[bus_addr[3:1]] <= bus_wdata[BANK_W-1:0];
			bank_mode               <= BANKED;
		end
	end

	// 512 KB pages, slot chosen by address bits 21 to 19
	always_comb begin
		if (bank_mode == BANKED)
			rom_addr = {bank_reg[bus_addr[21:19]], bus_addr[18:1]};
		else
			rom_addr = bus_addr;
	end

	// The bus FSM only ever selects one register block per cycle
	a_one_reg_write: assert property (@(posedge MCLK) disable iff (reset)
		!(ctrl_wr && bank_wr));

endmodule

`default_nettype wire

// File: work_ram.sv
/*
 * 64 KB work RAM
 * Synchronous 32K x 16 memory with independent upper and lower byte lanes
 */
`default_nettype none
`timescale 1ns/1ps

module work_ram (
	input  wire logic                        MCLK,
	input  wire logic                        ram_sel,
	input  wire logic [mbus_pkg::ADDR_W:1]   bus_addr,
	input  wire logic                        bus_rnw,
	input  wire logic [mbus_pkg::DATA_W-1:0] bus_wdata,
	input  wire logic                        bus_uds_n,
	input  wire logic                        bus_lds_n,
	output logic [mbus_pkg::DATA_W-1:0]      ram_q
);

	import mbus_pkg::*;

	localparam int LANE_W = DATA_W / 2;

	logic [RAM_AW-1:0] word_addr;
	logic [1:0]        lane_we;

	// Mirrors every 64 KB, upper address bits ignored
	assign word_addr = bus_addr[RAM_AW:1];

	// Lane 1 is the upper byte
	assign lane_we = {~bus_uds_n, ~bus_lds_n} & {2{ram_sel & ~bus_rnw}};

	for (genvar l = 0; l < 2; l++) begin : g_lane
		logic [LANE_W-1:0] mem [RAM_WORDS];
		logic [LANE_W-1:0] q;

		always_ff @(posedge MCLK) begin
			if (lane_we[l])
				mem[word_addr] <= bus_wdata[l*LANE_W +: LANE_W];
			q <= mem[word_addr];
		end

		assign ram_q[l*LANE_W +: LANE_W] = q;
	end

endmodule

`default_nettype wire

// File: mbus_ctrl.sv
/*
 * Main bus controller
 * Arbitrates CPU and DMA, runs the bus FSM, ROM handshake and open-bus tracking
 */
`default_nettype none
`timescale 1ns/1ps

module mbus_ctrl (
	input  wire logic                        MCLK,
	input  wire logic                        reset,
	// CPU port
	input  wire logic                        cpu_as_n,
	input  wire logic [mbus_pkg::ADDR_W:1]   cpu_addr,
	input  wire logic                        cpu_rnw,
	input  wire logic [mbus_pkg::DATA_W-1:0] cpu_wdata,
	input  wire logic                        cpu_uds_n,
	input  wire logic                        cpu_lds_n,
	output logic [mbus_pkg::DATA_W-1:0]      cpu_rdata,
	output logic                             cpu_dtack_n,
	// DMA port, read only
	input  wire logic                        dma_sel,
	input  wire logic [mbus_pkg::ADDR_W:1]   dma_addr,
	output logic [mbus_pkg::DATA_W-1:0]      dma_rdata,
	output logic                             dma_dtack_n,
	// ROM port
	output logic                             rom_req,
	input  wire logic                        rom_ack,
	output logic                             rom_we,
	output logic [mbus_pkg::DATA_W-1:0]      rom_wdata,
	output logic [1:0]                       rom_be,
	input  wire logic [mbus_pkg::DATA_W-1:0] rom_data,
	// Datapath blocks
	input  wire mbus_pkg::region_t           region,
	input  wire logic [mbus_pkg::DATA_W-1:0] ram_q,
	input  wire logic                        ctrl_rdbit,
	output logic [mbus_pkg::ADDR_W:1]        bus_addr,
	output logic                             bus_rnw,
	output logic [mbus_pkg::DATA_W-1:0]      bus_wdata,
	output logic                             bus_uds_n,
	output logic                             bus_lds_n,
	output logic                             ram_sel,
	output logic                             ctrl_wr,
	output logic                             bank_wr
);

	import mbus_pkg::*;

	mstate_t           state;
	msrc_t             msrc;
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] open_bus;
	logic              acks_clear;
	logic              cpu_read;

	// No new grant until the previous master has seen its DTACK drop
	assign acks_clear = cpu_dtack_n & dma_dtack_n;
	assign cpu_read   = (msrc == CPU) && bus_rnw;

	// ------------------------------
	// Select pulses
	// ------------------------------
	assign ram_sel = (state == SELECT) && (region == RAM);
	// Bit 8 sits in the upper byte
	assign ctrl_wr = (state == SELECT) && (region == CTRL) && !bus_rnw && !bus_uds_n;
	assign bank_wr = (state == SELECT) && (region == BANK) && !bus_rnw;

	assign rom_wdata = bus_wdata;
	assign rom_be    = ~{bus_uds_n, bus_lds_n};

	// ------------------------------
	// Bus FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= IDLE;
			msrc        <= NONE;
			cpu_dtack_n <= 1'b1;
			dma_dtack_n <= 1'b1;
			rom_req     <= rom_ack;
			rom_we      <= 1'b0;
			open_bus    <= NOP_WORD;
			bus_rnw     <= 1'b1;
			bus_uds_n   <= 1'b1;
			bus_lds_n   <= 1'b1;
		end else begin
			// Acknowledge is held until the master ends its cycle
			if (cpu_as_n)
				cpu_dtack_n <= 1'b1;
			if (!dma_sel)
				dma_dtack_n <= 1'b1;

			case (state)
				IDLE: begin
					// CPU wins a tie
					if (!cpu_as_n && cpu_dtack_n && acks_clear) begin
						msrc      <= CPU;
						bus_addr  <= cpu_addr;
						bus_rnw   <= cpu_rnw;
						bus_wdata <= cpu_wdata;
						bus_uds_n <= cpu_uds_n;
						bus_lds_n <= cpu_lds_n;
						state     <= SELECT;
					end else if (dma_sel && dma_dtack_n && acks_clear) begin
						msrc      <= DMA;
						bus_addr  <= dma_addr;
						bus_rnw   <= 1'b1;
						bus_wdata <= '0;
						bus_uds_n <= 1'b0;
						bus_lds_n <= 1'b0;
						state     <= SELECT;
					end
				end

				SELECT: begin
					// Default for registers and unmapped space
					rdata_q <= open_bus;
					state   <= FINISH;
					case (region)
						ROM:       state <= ROM_READ;
						RAM:       state <= RAM_READ;
						ROM_EMPTY: rdata_q <= '0;
						CTRL:      rdata_q <= {open_bus[15:9], ctrl_rdbit, open_bus[7:0]};
						default:   rdata_q <= open_bus;
					endcase
				end

				ROM_READ: begin
					// Address is translated by now, start the transfer
					rom_we  <= (msrc == CPU) && !bus_rnw;
					rom_req <= ~rom_req;
					state   <= ROM_WAIT;
				end

				ROM_WAIT: begin
					if (rom_req == rom_ack) begin
						rdata_q <= rom_data;
						if (cpu_read)
							open_bus <= rom_data;
						state <= FINISH;
					end
				end

				RAM_READ: begin
					rdata_q <= ram_q;
					if (cpu_read)
						open_bus <= ram_q;
					state <= FINISH;
				end

				FINISH: begin
					if (msrc == CPU) begin
						cpu_rdata   <= rdata_q;
						cpu_dtack_n <= 1'b0;
					end else begin
						dma_rdata   <= rdata_q;
						dma_dtack_n <= 1'b0;
					end
					msrc  <= NONE;
					state <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	// Holds only because grants wait for both acknowledges to clear
	a_single_dtack: assert property (@(posedge MCLK) disable iff (reset)
		!(!cpu_dtack_n && !dma_dtack_n));

	// Memory sees exactly one request per ROM cycle
	a_rom_req_entry: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> (state == ROM_WAIT) && ($past(state) == ROM_READ));

endmodule

`default_nettype wire

// File: mbus_top.sv
/*
 * Main bus arbiter top level
 * Joins the bus FSM with the decoder, system registers and work RAM
 */
`default_nettype none
`timescale 1ns/1ps

module mbus_top (
	input  wire logic                        MCLK,
	input  wire logic                        reset,
	// CPU port
	input  wire logic                        cpu_as_n,
	input  wire logic [mbus_pkg::ADDR_W:1]   cpu_addr,
	input  wire logic                        cpu_rnw,
	input  wire logic [mbus_pkg::DATA_W-1:0] cpu_wdata,
	input  wire logic                        cpu_uds_n,
	input  wire logic                        cpu_lds_n,
	output logic [mbus_pkg::DATA_W-1:0]      cpu_rdata,
	output logic                             cpu_dtack_n,
	// DMA port
	input  wire logic                        dma_sel,
	input  wire logic [mbus_pkg::ADDR_W:1]   dma_addr,
	output logic [mbus_pkg::DATA_W-1:0]      dma_rdata,
	output logic                             dma_dtack_n,
	// ROM port
	output logic [mbus_pkg::ADDR_W:1]        rom_addr,
	output logic                             rom_req,
	input  wire logic                        rom_ack,
	output logic                             rom_we,
	output logic [mbus_pkg::DATA_W-1:0]      rom_wdata,
	output logic [1:0]                       rom_be,
	input  wire logic [mbus_pkg::DATA_W-1:0] rom_data,
	input  wire logic [mbus_pkg::ADDR_W:1]   rom_size,
	// Z80 control
	input  wire logic                        z80_busak_n,
	output logic                             z80_busreq_n,
	output logic                             z80_reset_n
);

	import mbus_pkg::*;

	logic [ADDR_W:1]   bus_addr;
	logic              bus_rnw;
	logic [DATA_W-1:0] bus_wdata;
	logic              bus_uds_n;
	logic              bus_lds_n;
	region_t           region;
	logic [DATA_W-1:0] ram_q;
	logic              ctrl_rdbit;
	logic              ram_sel;
	logic              ctrl_wr;
	logic              bank_wr;

	mbus_ctrl mbus_ctrl_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.cpu_as_n    (cpu_as_n),
		.cpu_addr    (cpu_addr),
		.cpu_rnw     (cpu_rnw),
		.cpu_wdata   (cpu_wdata),
		.cpu_uds_n   (cpu_uds_n),
		.cpu_lds_n   (cpu_lds_n),
		.cpu_rdata   (cpu_rdata),
		.cpu_dtack_n (cpu_dtack_n),
		.dma_sel     (dma_sel),
		.dma_addr    (dma_addr),
		.dma_rdata   (dma_rdata),
		.dma_dtack_n (dma_dtack_n),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_we      (rom_we),
		.rom_wdata   (rom_wdata),
		.rom_be      (rom_be),
		.rom_data    (rom_data),
		.region      (region),
		.ram_q       (ram_q),
		.ctrl_rdbit  (ctrl_rdbit),
		.bus_addr    (bus_addr),
		.bus_rnw     (bus_rnw),
		.bus_wdata   (bus_wdata),
		.bus_uds_n   (bus_uds_n),
		.bus_lds_n   (bus_lds_n),
		.ram_sel     (ram_sel),
		.ctrl_wr     (ctrl_wr),
		.bank_wr     (bank_wr)
	);

	mbus_decode mbus_decode_i (
		.bus_addr (bus_addr),
		.rom_size (rom_size),
		.region   (region)
	);

	system_regs system_regs_i (
		.MCLK         (MCLK),
		.reset        (reset),
		.ctrl_wr      (ctrl_wr),
		.bank_wr      (bank_wr),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.z80_busak_n  (z80_busak_n),
		.ctrl_rdbit   (ctrl_rdbit),
		.rom_addr     (rom_addr),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	work_ram work_ram_i (
		.MCLK      (MCLK),
		.ram_sel   (ram_sel),
		.bus_addr  (bus_addr),
		.bus_rnw   (bus_rnw),
		.bus_wdata (bus_wdata),
		.bus_uds_n (bus_uds_n),
		.bus_lds_n (bus_lds_n),
		.ram_q     (ram_q)
	);

endmodule

`default_nettype wire

// File: tb_mbus.sv
/*
 * Main bus arbiter testbench
 * Runs CPU and DMA bus operations from a pattern file against a ROM model
 */
`default_nettype none
`timescale 1ns/1ps

module tb_mbus;

	import mbus_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic              MCLK;
	logic              reset;
	logic              cpu_as_n;
	logic [ADDR_W:1]   cpu_addr;
	logic              cpu_rnw;
	logic [DATA_W-1:0] cpu_wdata;
	logic              cpu_uds_n;
	logic              cpu_lds_n;
	logic [DATA_W-1:0] cpu_rdata;
	logic              cpu_dtack_n;
	logic              dma_sel;
	logic [ADDR_W:1]   dma_addr;
	logic [DATA_W-1:0] dma_rdata;
	logic              dma_dtack_n;
	logic [ADDR_W:1]   rom_addr;
	logic              rom_req;
	logic              rom_ack;
	logic              rom_we;
	logic [DATA_W-1:0] rom_wdata;
	logic [1:0]        rom_be;
	logic [DATA_W-1:0] rom_data;
	logic [ADDR_W:1]   rom_size;
	logic              z80_busak_n;
	logic              z80_busreq_n;
	logic              z80_reset_n;

	// ROM model state
	logic              rom_busy;
	int unsigned       rom_delay;
	int unsigned       rom_reqs;
	logic [ADDR_W:1]   last_rom_addr;
	logic              last_rom_we;
	logic [DATA_W-1:0] last_rom_wdata;
	logic [1:0]        last_rom_be;

	int unsigned       seed_val;
	int                errors;
	int                checks;
	int                passed;
	int                failed;
	logic              aborted;

	mbus_top mbus_top_i (
		.MCLK         (MCLK),
		.reset        (reset),
		.cpu_as_n     (cpu_as_n),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_wdata    (cpu_wdata),
		.cpu_uds_n    (cpu_uds_n),
		.cpu_lds_n    (cpu_lds_n),
		.cpu_rdata    (cpu_rdata),
		.cpu_dtack_n  (cpu_dtack_n),
		.dma_sel      (dma_sel),
		.dma_addr     (dma_addr),
		.dma_rdata    (dma_rdata),
		.dma_dtack_n  (dma_dtack_n),
		.rom_addr     (rom_addr),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.rom_we       (rom_we),
		.rom_wdata    (rom_wdata),
		.rom_be       (rom_be),
		.rom_data     (rom_data),
		.rom_size     (rom_size),
		.z80_busak_n  (z80_busak_n),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	initial MCLK = 1'b0;
	always #5 MCLK = ~MCLK;

	// ------------------------------
	// ROM and Z80 models
	// ------------------------------
	initial begin
		// Answer delays come from a fixed seed
		seed_val       = $urandom(99731);
		rom_ack        = 1'b0;
		rom_data       = '0;
		rom_busy       = 1'b0;
		rom_delay      = 0;
		rom_reqs       = 0;
		last_rom_addr  = '0;
		last_rom_we    = 1'b0;
		last_rom_wdata = '0;
		last_rom_be    = '0;
		forever begin
			@(negedge MCLK);
			if (!rom_busy && !reset && (rom_req != rom_ack)) begin
				rom_busy       = 1'b1;
				rom_delay      = $urandom_range(5, 0);
				rom_reqs++;
				last_rom_addr  = rom_addr;
				last_rom_we    = rom_we;
				last_rom_wdata = rom_wdata;
				last_rom_be    = rom_be;
			end
			if (rom_busy) begin
				if (rom_delay == 0) begin
					// Word address low bits with a fixed pattern on top
					rom_data = last_rom_addr[16:1] ^ 16'hA5A5;
					rom_ack  = rom_req;
					rom_busy = 1'b0;
				end else begin
					rom_delay--;
				end
			end
		end
	end

	// Z80 grants the bus one clock after a request
	initial begin
		z80_busak_n = 1'b1;
		forever begin
			@(negedge MCLK);
			z80_busak_n = z80_busreq_n;
		end
	end

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_strobes(input logic [1:0] got, input logic [1:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input logic [ADDR_W:1] got, input logic [ADDR_W:1] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s was %h, expected %h", $time, what,
				{got, 1'b0}, {exp, 1'b0});
		end
	endtask

	// Direction, lanes and write data of a ROM request made during the last cycle
	task automatic check_rom_side(input int unsigned reqs_before, input logic we,
		input logic [DATA_W-1:0] wdata, input logic [1:0] be);
		if (rom_reqs != reqs_before) begin
			check_bit(last_rom_we, we, "rom_we");
			check_strobes(last_rom_be, be, "rom_be");
			if (we)
				check_word(last_rom_wdata, wdata, "rom_wdata");
		end
	endtask

	// ------------------------------
	// Bus masters
	// ------------------------------
	task automatic cpu_cycle(input logic rnw, input logic [ADDR_W:1] addr,
		input logic [DATA_W-1:0] wdata, input logic [1:0] be,
		output logic [DATA_W-1:0] rdata);
		int n;
		n = 0;
		@(negedge MCLK);
		cpu_addr  = addr;
		cpu_rnw   = rnw;
		cpu_wdata = wdata;
		cpu_uds_n = ~be[1];
		cpu_lds_n = ~be[0];
		cpu_as_n  = 1'b0;
		@(negedge MCLK);
		while (cpu_dtack_n && (n < WAIT_LIMIT)) begin
			@(negedge MCLK);
			n++;
		end
		if (cpu_dtack_n) begin
			$display("CPU cycle at address %h never got DTACK", {addr, 1'b0});
			errors++;
			aborted = 1'b1;
		end
		rdata    = cpu_rdata;
		cpu_as_n = 1'b1;
	endtask

	task automatic dma_cycle(input logic [ADDR_W:1] addr, input logic solo,
		output logic [DATA_W-1:0] rdata);
		int n;
		n = 0;
		@(negedge MCLK);
		dma_addr = addr;
		dma_sel  = 1'b1;
		do begin
			@(negedge MCLK);
			n++;
			// With no CPU traffic only the DMA side may be acknowledged
			if (solo && !cpu_dtack_n) begin
				$display("CPU DTACK went low during a DMA cycle at %0d ns", $time);
				errors++;
			end
		end while (dma_dtack_n && (n < WAIT_LIMIT));
		if (dma_dtack_n) begin
			$display("DMA cycle at address %h never got DTACK", {addr, 1'b0});
			errors++;
			aborted = 1'b1;
		end
		rdata   = dma_rdata;
		dma_sel = 1'b0;
	endtask

	task automatic run_op(input logic [7:0] op, input logic [ADDR_W:1] addr,
		input logic [DATA_W-1:0] data, input logic [1:0] be);
		logic [DATA_W-1:0] got;
		logic [DATA_W-1:0] got_dma;
		int unsigned       reqs;
		reqs = rom_reqs;
		case (op)
			"W": begin
				cpu_cycle(1'b0, addr, data, be, got);
				check_rom_side(reqs, 1'b1, data, be);
			end
			"R": begin
				cpu_cycle(1'b1, addr, '0, be, got);
				check_word(got, data, $sformatf("CPU read of %h", {addr, 1'b0}));
				check_rom_side(reqs, 1'b0, '0, be);
			end
			"D": begin
				dma_cycle(addr, 1'b1, got);
				check_word(got, data, $sformatf("DMA read of %h", {addr, 1'b0}));
				check_rom_side(reqs, 1'b0, '0, 2'b11);
			end
			"I": begin
				fork
					cpu_cycle(1'b1, addr, '0, be, got);
					dma_cycle(addr, 1'b0, got_dma);
				join
				check_word(got, data, $sformatf("CPU read of %h", {addr, 1'b0}));
				check_word(got_dma, data, $sformatf("DMA read of %h", {addr, 1'b0}));
			end
			"Z": begin
				@(negedge MCLK);
				check_bit(z80_busreq_n, data[1], "z80_busreq_n");
				check_bit(z80_reset_n, data[0], "z80_reset_n");
			end
			"A": check_addr(last_rom_addr, addr, "last ROM request address");
			default: begin
				$display("Unknown operation %c in the pattern file", op);
				errors++;
				aborted = 1'b1;
			end
		endcase
	endtask

	task automatic close_test(input int id, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %0d: pass", id);
		end else begin
			failed++;
			$display("test %0d: %0d errors", id, errors - errs_before);
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int                fd;
		int                n;
		int                tid;
		int                cur_tid;
		int                errs_at_start;
		logic [7:0]        op;
		logic [23:0]       baddr;
		logic [DATA_W-1:0] data;
		logic [1:0]        be;
		string             line;

		errors    = 0;
		checks    = 0;
		passed    = 0;
		failed    = 0;
		aborted   = 1'b0;
		reset     = 1'b1;
		cpu_as_n  = 1'b1;
		cpu_addr  = '0;
		cpu_rnw   = 1'b1;
		cpu_wdata = '0;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		dma_sel   = 1'b0;
		dma_addr  = '0;
		// 2 MB image, given as a word address
		rom_size  = 23'h100000;

		repeat (10) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;

		cur_tid       = -1;
		errs_at_start = 0;
		fd = $fopen("mbus_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file mbus_patterns.txt");
			errors++;
		end

		// Comment and blank lines do not scan and are skipped
		while ((fd != 0) && !aborted && ($fgets(line, fd) > 0)) begin
			n = $sscanf(line, "%d %c %h %h %h", tid, op, baddr, data, be);
			if (n == 5) begin
				if (tid != cur_tid) begin
					if (cur_tid >= 0)
						close_test(cur_tid, errs_at_start);
					cur_tid       = tid;
					errs_at_start = errors;
				end
				run_op(op, baddr[23:1], data, be);
			end
		end
		if (cur_tid >= 0)
			close_test(cur_tid, errs_at_start);
		if (fd != 0)
			$fclose(fd);

		$display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
			passed, failed, checks, errors);
		if ((errors != 0) || (checks == 0)) begin
			$display("Test FAILED");
		end else begin
			$display("Test OK");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mbus_patterns.txt
# test op byte_addr data strobes  (op: W/R CPU write/read, D DMA read, I CPU and DMA read
# together, Z z80 pins busreq_n:reset_n in data bits 1:0, A last ROM request byte address)
3 R C00000 4E71 3
3 W E00020 C0DE 3
3 R E00020 C0DE 3
3 R C00000 C0DE 3
3 R 000100 A525 3
3 R C00000 A525 3
3 W E00030 7777 3
3 D E00030 7777 3
3 D 000200 A4A5 3
3 R C00000 A525 3
2 R 000000 A5A5 3
2 R 012346 3406 3
2 A 012346 0000 0
2 R 300000 0000 3
2 R 9FFFFE 0000 3
1 W E00010 1234 3
1 R E00010 1234 3
1 W E00010 AB00 2
1 R E00010 AB34 3
1 W E00010 00CD 1
1 R E00010 ABCD 3
1 R F30010 ABCD 3
1 W FFFFFE 5AA5 3
1 R EFFFFE 5AA5 3
4 Z 000000 0002 0
4 R A11100 5BA5 3
4 R A11200 5AA5 3
4 W A11100 0100 3
4 W A11200 0100 3
4 Z 000000 0001 0
4 R A11100 5AA5 3
4 R A11200 5BA5 3
5 W A13002 0003 3
5 R 080000 A5A5 3
5 A 180000 0000 0
5 R 080ABC A0FB 3
5 A 180ABC 0000 0
5 W A13000 0007 3
5 R 000000 A5A5 3
5 A 000000 0000 0
6 W E01000 BEEF 3
6 D E01000 BEEF 3
6 W E01002 1357 3
6 I E01002 1357 3
6 D F01000 BEEF 3

// File: src.f
mbus_pkg.sv
mbus_decode.sv
system_regs.sv
work_ram.sv
mbus_ctrl.sv
mbus_top.sv
tb_mbus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the main bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_mbus \
	-f src.f \
	-o sim_mbus

./obj_dir/sim_mbus | tee sim.log

if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
